/* build.f */
verilog/l2c_pkg.sv
verilog/l2c_splitter.sv
verilog/l2c_target_mem.sv
verilog/l2c_resp_arbiter.sv
verilog/l2c_subsystem_top.sv
verif/tb_l2c_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_l2c_subsystem
OBJ_DIR=obj_dir
LOG=sim.log
FAIL_MSG="sim failed"

if ! rm -rf "$OBJ_DIR"; then
   echo "could not clear $OBJ_DIR"
   exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module "$TOP" -Mdir "$OBJ_DIR" -f build.f; then
   echo "Verilator build step returned an error"
   exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?

if ! cat "$LOG"; then
   echo "could not read $LOG"
   exit 1
fi

if [ "$run_status" -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

# The testbench verdict lives in the log
if grep -q "$FAIL_MSG" "$LOG"; then
   echo "RESULT: FAIL (see $LOG)"
   exit 1
fi

echo "RESULT: PASS"
exit 0

/* verif/tb_l2c_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_l2c_subsystem;

   import l2c_pkg::*;

   localparam int TAG_W         = 4;
   localparam int MEM_AW        = 6;
   localparam int NUM_TAGS      = 1 << TAG_W;
   localparam int MAX_ENTRIES   = 40;
   localparam int NUM_TESTS     = 5;
   localparam int GROUP_TIMEOUT = 400;

   logic                clk;
   logic                reset;
   logic                req_valid;
   req_payload_t        req_payload;
   logic [TAG_W-1:0]    req_tag;
   logic                req_ready;
   logic                resp_valid;
   resp_payload_t       resp_payload;
   logic [TAG_W-1:0]    resp_tag;
   logic                resp_ready;

   // Stimulus table
   int                  tbl_grp  [MAX_ENTRIES];
   mem_cmd_t            tbl_cmd  [MAX_ENTRIES];
   logic [31:0]         tbl_addr [MAX_ENTRIES];
   logic [31:0]         tbl_data [MAX_ENTRIES];
   logic [3:0]          tbl_be   [MAX_ENTRIES];
   logic [31:0]         tbl_exp  [MAX_ENTRIES];
   int                  num_entries = 0;

   // Expected data by tag
   logic [31:0]         exp_by_tag [NUM_TAGS];
   bit [NUM_TAGS-1:0]   pending = '0;

   logic [16:0]         lfsr_state = 17'd97871;
   int                  errors = 0;
   int                  checks = 0;
   int                  tests_passed = 0;
   int                  tests_failed = 0;
   bit                  timed_out = 1'b0;

   l2c_subsystem_top #(
      .TAG_W  (TAG_W),
      .MEM_AW (MEM_AW)
   ) u_l2c_subsystem_top (
      .i_clk          (clk),
      .i_reset        (reset),
      .i_req_valid    (req_valid),
      .i_req_payload  (req_payload),
      .i_req_tag      (req_tag),
      .o_req_ready    (req_ready),
      .o_resp_valid   (resp_valid),
      .o_resp_payload (resp_payload),
      .o_resp_tag     (resp_tag),
      .i_resp_ready   (resp_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // x^17 + x^14 + 1
   function automatic logic [16:0] lfsr_step(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   function automatic logic [31:0] apply_byte_enables(input logic [31:0] old_word,
                                                      input logic [31:0] new_word,
                                                      input logic [3:0] be);
      logic [31:0] mask;
      mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      return (new_word & mask) | (old_word & ~mask);
   endfunction

   function automatic string test_name(input int grp);
      case (grp)
         1: return "idle after reset and first reads";
         2: return "per-region write then read";
         3: return "partial byte enables";
         4: return "boundary routing";
         default: return "random back-pressure over regions";
      endcase
   endfunction

   task automatic add_entry(input int grp, input mem_cmd_t cmd, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] be,
                            input logic [31:0] exp_data);
      tbl_grp[num_entries]  = grp;
      tbl_cmd[num_entries]  = cmd;
      tbl_addr[num_entries] = addr;
      tbl_data[num_entries] = data;
      tbl_be[num_entries]   = be;
      tbl_exp[num_entries]  = exp_data;
      num_entries++;
   endtask

   // ====================
   // Table
   // ====================
   task automatic build_table();
      logic [31:0] merged;
      merged = apply_byte_enables(32'h1122_3344, 32'haabb_ccdd, 4'b0101);
      // Unwritten words in every region
      add_entry(1, CMD_RD, 32'h0000_1020, 32'h0, 4'hf, 32'h0);
      add_entry(1, CMD_RD, 32'h5400_0020, 32'h0, 4'hf, 32'h0);
      add_entry(1, CMD_RD, 32'h8020_0020, 32'h0, 4'hf, 32'h0);
      add_entry(1, CMD_RD, 32'hffc8_4a20, 32'h0, 4'hf, 32'h0);
      add_entry(1, CMD_RD, 32'h1000_0020, 32'h0, 4'hf, 32'h0);
      // Same word offset in separate storage
      add_entry(2, CMD_WR, 32'h0000_1010, 32'hb007_0001, 4'hf, 32'h0);
      add_entry(2, CMD_WR, 32'h5400_0010, 32'h5e41_0002, 4'hf, 32'h0);
      add_entry(2, CMD_WR, 32'h8020_0010, 32'hce41_0003, 4'hf, 32'h0);
      add_entry(2, CMD_WR, 32'hffc8_4a10, 32'h141d_0004, 4'hf, 32'h0);
      add_entry(2, CMD_WR, 32'h2000_0010, 32'h12c0_0005, 4'hf, 32'h0);
      add_entry(2, CMD_RD, 32'h0000_1010, 32'h0, 4'hf, 32'hb007_0001);
      add_entry(2, CMD_RD, 32'h5400_0010, 32'h0, 4'hf, 32'h5e41_0002);
      add_entry(2, CMD_RD, 32'h8020_0010, 32'h0, 4'hf, 32'hce41_0003);
      add_entry(2, CMD_RD, 32'hffc8_4a10, 32'h0, 4'hf, 32'h141d_0004);
      add_entry(2, CMD_RD, 32'h2000_0010, 32'h0, 4'hf, 32'h12c0_0005);
      add_entry(3, CMD_WR, 32'h8020_0040, 32'h1122_3344, 4'hf, 32'h0);
      add_entry(3, CMD_WR, 32'h8020_0040, 32'haabb_ccdd, 4'b0101, 32'h0);
      add_entry(3, CMD_RD, 32'h8020_0040, 32'h0, 4'hf, merged);
      // Both sides of the kernel and initrd limits
      add_entry(4, CMD_WR, 32'h821f_fffc, 32'h4b00_0001, 4'hf, 32'h0);
      add_entry(4, CMD_WR, 32'h8220_0000, 32'h4c00_0002, 4'hf, 32'h0);
      add_entry(4, CMD_WR, 32'hffc8_4a00, 32'h4d00_0003, 4'hf, 32'h0);
      add_entry(4, CMD_WR, 32'hffc8_49fc, 32'h4e00_0004, 4'hf, 32'h0);
      add_entry(4, CMD_RD, 32'h8020_00fc, 32'h0, 4'hf, 32'h4b00_0001);
      add_entry(4, CMD_RD, 32'h0000_0000, 32'h0, 4'hf, 32'h4c00_0002);
      add_entry(4, CMD_RD, 32'hffff_ef00, 32'h0, 4'hf, 32'h4d00_0003);
      add_entry(4, CMD_RD, 32'h0000_00fc, 32'h0, 4'hf, 32'h4e00_0004);
      // Back to back with two to kernel
      add_entry(5, CMD_RD, 32'h8020_0010, 32'h0, 4'hf, 32'hce41_0003);
      add_entry(5, CMD_RD, 32'h0000_1010, 32'h0, 4'hf, 32'hb007_0001);
      add_entry(5, CMD_RD, 32'h8020_0040, 32'h0, 4'hf, merged);
      add_entry(5, CMD_RD, 32'h5400_0010, 32'h0, 4'hf, 32'h5e41_0002);
      add_entry(5, CMD_RD, 32'hffc8_4a10, 32'h0, 4'hf, 32'h141d_0004);
      add_entry(5, CMD_RD, 32'h2000_0010, 32'h0, 4'hf, 32'h12c0_0005);
   endtask

   task automatic score_response();
      logic [TAG_W-1:0] t;
      t = resp_tag;
      checks++;
      if (!pending[t]) begin
         $display("t=%0t: response with tag %0d arrived but no request holds that tag",
                  $time, t);
         errors++;
      end else begin
         if (resp_payload.data !== exp_by_tag[t]) begin
            $display("ERR t=%0t o_resp_payload.data tag %0d got %h expected %h",
                     $time, t, resp_payload.data, exp_by_tag[t]);
            errors++;
         end
         pending[t] = 1'b0;
      end
   endtask

   // ====================
   // One test group
   // ====================
   task automatic run_group(input int grp, input bit use_bp);
      int               list [$];
      int               pos;
      int               cur;
      int               cycles;
      bit               req_active;
      bit               stalled;
      resp_payload_t    held_payload;
      logic [TAG_W-1:0] held_tag;
      logic [TAG_W-1:0] tag;
      pos        = 0;
      cur        = 0;
      cycles     = 0;
      req_active = 1'b0;
      stalled    = 1'b0;
      tag        = '0;
      for (int i = 0; i < num_entries; i++) begin
         if (tbl_grp[i] == grp) begin
            list.push_back(i);
         end
      end
      while (pos < list.size() || pending != '0) begin
         @(negedge clk);
         if (use_bp) begin
            resp_ready = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
         end else begin
            resp_ready = 1'b1;
         end
         if (!req_active) begin
            req_valid = 1'b0;
            if (pos < list.size()) begin
               cur = list[pos];
               tag = TAG_W'(cur % NUM_TAGS);
               // Hold off while the previous owner of this tag is out
               if (!pending[tag]) begin
                  req_payload.cmd     = tbl_cmd[cur];
                  req_payload.addr    = tbl_addr[cur];
                  req_payload.data    = tbl_data[cur];
                  req_payload.byte_en = tbl_be[cur];
                  req_tag             = tag;
                  req_valid           = 1'b1;
                  req_active          = 1'b1;
               end
            end
         end
         #1;
         if (stalled) begin
            checks++;
            if (!resp_valid) begin
               $display("t=%0t: o_resp_valid fell before the stalled response was taken",
                        $time);
               errors++;
            end else begin
               if (resp_payload !== held_payload) begin
                  $display("ERR t=%0t o_resp_payload got %h expected %h",
                           $time, resp_payload, held_payload);
                  errors++;
               end
               if (resp_tag !== held_tag) begin
                  $display("ERR t=%0t o_resp_tag got %h expected %h",
                           $time, resp_tag, held_tag);
                  errors++;
               end
            end
         end
         if (resp_valid && resp_ready) begin
            score_response();
         end
         stalled      = resp_valid && !resp_ready;
         held_payload = resp_payload;
         held_tag     = resp_tag;
         if (req_active && req_ready) begin
            exp_by_tag[tag] = tbl_exp[cur];
            pending[tag]    = 1'b1;
            req_active      = 1'b0;
            pos++;
         end
         cycles++;
         if (cycles >= GROUP_TIMEOUT) begin
            $display("t=%0t: test %0d timed out with %0d of %0d requests sent, tags %b open",
                     $time, grp, pos, list.size(), pending);
            timed_out = 1'b1;
            break;
         end
      end
   endtask

   task automatic report_test(input int grp, input int err_base);
      if (errors == err_base && !timed_out) begin
         tests_passed++;
         $display("test %0d %s: PASS", grp, test_name(grp));
      end else begin
         tests_failed++;
         $display("test %0d %s: FAIL with %0d errors", grp, test_name(grp), errors - err_base);
      end
   endtask

   initial begin
      int err_base;
      reset       = 1'b1;
      req_valid   = 1'b0;
      req_payload = '0;
      req_tag     = '0;
      resp_ready  = 1'b1;
      build_table();
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int g = 1; g <= NUM_TESTS; g++) begin
         if (!timed_out) begin
            err_base = errors;
            if (g == 1) begin
               #1;
               checks++;
               if (resp_valid !== 1'b0) begin
                  $display("ERR t=%0t o_resp_valid got %b expected 0", $time, resp_valid);
                  errors++;
               end
            end
            run_group(g, g == NUM_TESTS);
            report_test(g, err_base);
         end
      end
      $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed, tests_failed, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/l2c_subsystem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_subsystem_top #(
   parameter int TAG_W  = 4,
   parameter int MEM_AW = 6
) (
   input  logic                     i_clk,
   input  logic                     i_reset,

   input  logic                     i_req_valid,
   input  l2c_pkg::req_payload_t    i_req_payload,
   input  logic [TAG_W-1:0]         i_req_tag,
   output logic                     o_req_ready,

   output logic                     o_resp_valid,
   output l2c_pkg::resp_payload_t   o_resp_payload,
   output logic [TAG_W-1:0]         o_resp_tag,
   input  logic                     i_resp_ready
);

   import l2c_pkg::*;

   logic [NUM_TGT-1:0]  w_tgt_req_valid;
   logic [NUM_TGT-1:0]  w_tgt_req_ready;
   logic [NUM_TGT-1:0]  w_tgt_resp_valid;
   logic [NUM_TGT-1:0]  w_tgt_resp_ready;
   resp_payload_t       w_tgt_resp_payload [NUM_TGT];
   logic [TAG_W-1:0]    w_tgt_resp_tag [NUM_TGT];

   l2c_splitter u_l2c_splitter (
      .i_req_valid      (i_req_valid),
      .i_req_payload    (i_req_payload),
      .o_tgt_req_valid  (w_tgt_req_valid),
      .i_tgt_req_ready  (w_tgt_req_ready),
      .o_req_ready      (o_req_ready)
   );

   // ====================
   // Region targets
   // ====================
   // Indexed by region_t, payload and tag are broadcast
   for (genvar g = 0; g < NUM_TGT; g++) begin : g_tgt
      l2c_target_mem #(
         .TAG_W   (TAG_W),
         .MEM_AW  (MEM_AW)
      ) u_l2c_target_mem (
         .i_clk          (i_clk),
         .i_reset        (i_reset),
         .i_req_valid    (w_tgt_req_valid[g]),
         .i_req_payload  (i_req_payload),
         .i_req_tag      (i_req_tag),
         .o_req_ready    (w_tgt_req_ready[g]),
         .o_resp_valid   (w_tgt_resp_valid[g]),
         .o_resp_payload (w_tgt_resp_payload[g]),
         .o_resp_tag     (w_tgt_resp_tag[g]),
         .i_resp_ready   (w_tgt_resp_ready[g])
      );
   end

   l2c_resp_arbiter #(
      .TAG_W  (TAG_W)
   ) u_l2c_resp_arbiter (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_resp_valid   (w_tgt_resp_valid),
      .i_resp_payload (w_tgt_resp_payload),
      .i_resp_tag     (w_tgt_resp_tag),
      .o_resp_ready   (w_tgt_resp_ready),
      .o_resp_valid   (o_resp_valid),
      .o_resp_payload (o_resp_payload),
      .o_resp_tag     (o_resp_tag),
      .i_resp_ready   (i_resp_ready)
   );

endmodule

`default_nettype wire

/* verilog/l2c_resp_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_resp_arbiter #(
   parameter int TAG_W = 4
) (
   input  logic                           i_clk,
   input  logic                           i_reset,

   input  logic [l2c_pkg::NUM_TGT-1:0]    i_resp_valid,
   input  l2c_pkg::resp_payload_t         i_resp_payload [l2c_pkg::NUM_TGT],
   input  logic [TAG_W-1:0]               i_resp_tag [l2c_pkg::NUM_TGT],
   output logic [l2c_pkg::NUM_TGT-1:0]    o_resp_ready,

   output logic                           o_resp_valid,
   output l2c_pkg::resp_payload_t         o_resp_payload,
   output logic [TAG_W-1:0]               o_resp_tag,
   input  logic                           i_resp_ready
);

   import l2c_pkg::*;

   localparam int SEL_W = $clog2(NUM_TGT);

   logic [SEL_W-1:0]    r_ptr;
   logic                r_lock;
   logic [SEL_W-1:0]    r_lock_idx;

   logic                w_found;
   logic [SEL_W-1:0]    w_sel;
   logic [NUM_TGT-1:0]  w_grant;
   logic                w_xfer;

   // ====================
   // Grant selection
   // ====================
   // Search starts at the pointer, a held grant overrides it
   always_comb begin
      int idx;
      w_found = 1'b0;
      w_sel   = r_ptr;
      for (int k = 0; k < NUM_TGT; k++) begin
         idx = (int'(r_ptr) + k) % NUM_TGT;
         if (!w_found && i_resp_valid[idx]) begin
            w_found = 1'b1;
            w_sel   = SEL_W'(idx);
         end
      end
      if (r_lock) begin
         w_found = i_resp_valid[r_lock_idx];
         w_sel   = r_lock_idx;
      end
   end

   assign w_grant = w_found ? (NUM_TGT'(1) << w_sel) : '0;
   assign w_xfer  = w_found && i_resp_ready;

   assign o_resp_valid   = w_found;
   assign o_resp_payload = i_resp_payload[w_sel];
   assign o_resp_tag     = i_resp_tag[w_sel];
   assign o_resp_ready   = w_grant & {NUM_TGT{i_resp_ready}};

   // Pointer moves past the served target
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_ptr      <= '0;
         r_lock     <= 1'b0;
         r_lock_idx <= '0;
      end else if (w_xfer) begin
         r_ptr  <= (w_sel == SEL_W'(NUM_TGT - 1)) ? '0 : w_sel + 1'b1;
         r_lock <= 1'b0;
      end else if (w_found) begin
         r_lock     <= 1'b1;
         r_lock_idx <= w_sel;
      end
   end

   assert property (@(posedge i_clk) disable iff (i_reset)
      o_resp_valid |-> $onehot(w_grant))
      else $error("l2c_resp_arbiter: grant not one-hot");

   // Stalled output keeps the same target
   assert property (@(posedge i_clk) disable iff (i_reset)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && (w_grant == $past(w_grant)))
      else $error("l2c_resp_arbiter: grant moved while stalled");

endmodule

`default_nettype wire

/* verilog/l2c_target_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_target_mem #(
   parameter int TAG_W  = 4,
   parameter int MEM_AW = 6
) (
   input  logic                     i_clk,
   input  logic                     i_reset,

   input  logic                     i_req_valid,
   input  l2c_pkg::req_payload_t    i_req_payload,
   input  logic [TAG_W-1:0]         i_req_tag,
   output logic                     o_req_ready,

   output logic                     o_resp_valid,
   output l2c_pkg::resp_payload_t   o_resp_payload,
   output logic [TAG_W-1:0]         o_resp_tag,
   input  logic                     i_resp_ready
);

   import l2c_pkg::*;

   localparam int DEPTH = 1 << MEM_AW;

   logic [DATA_W-1:0]   r_mem [DEPTH];
   logic [DEPTH-1:0]    r_written;

   logic                r_resp_valid;
   resp_payload_t       r_resp_payload;
   logic [TAG_W-1:0]    r_resp_tag;

   logic [MEM_AW-1:0]   w_idx;
   logic                w_req_fire;
   logic                w_is_wr;
   logic [DATA_W-1:0]   w_rd_word;
   logic [DATA_W-1:0]   w_merged;

   // Word index from bit 2 upward
   assign w_idx      = i_req_payload.addr[MEM_AW+1:2];
   assign w_is_wr    = i_req_payload.cmd == CMD_WR;

   // Free slot, or the held response leaves this cycle
   assign o_req_ready = !r_resp_valid || i_resp_ready;
   assign w_req_fire  = i_req_valid && o_req_ready;

   // Unwritten words read as zero
   assign w_rd_word = r_written[w_idx] ? r_mem[w_idx] : '0;

   // ====================
   // Byte merge
   // ====================
   always_comb begin
      w_merged = w_rd_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (i_req_payload.byte_en[b]) begin
            w_merged[b*8 +: 8] = i_req_payload.data[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (w_req_fire && w_is_wr) begin
         r_mem[w_idx] <= w_merged;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_written <= '0;
      end else if (w_req_fire && w_is_wr) begin
         r_written[w_idx] <= 1'b1;
      end
   end

   // ====================
   // Response register
   // ====================
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_resp_valid <= 1'b0;
      end else if (w_req_fire) begin
         r_resp_valid <= 1'b1;
      end else if (i_resp_ready) begin
         r_resp_valid <= 1'b0;
      end
   end

   // Writes answer with zero data
   always_ff @(posedge i_clk) begin
      if (w_req_fire) begin
         r_resp_payload.data <= w_is_wr ? '0 : w_rd_word;
         r_resp_tag          <= i_req_tag;
      end
   end

   assign o_resp_valid   = r_resp_valid;
   assign o_resp_payload = r_resp_payload;
   assign o_resp_tag     = r_resp_tag;

   // Stalled response must hold until taken
   assert property (@(posedge i_clk) disable iff (i_reset)
      o_resp_valid && !i_resp_ready |=>
         o_resp_valid && $stable(o_resp_payload) && $stable(o_resp_tag))
      else $error("l2c_target_mem: response changed under back-pressure");

endmodule

`default_nettype wire

/* verilog/l2c_splitter.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_splitter (
   input  logic                           i_req_valid,
   input  l2c_pkg::req_payload_t          i_req_payload,
   output logic [l2c_pkg::NUM_TGT-1:0]    o_tgt_req_valid,
   input  logic [l2c_pkg::NUM_TGT-1:0]    i_tgt_req_ready,
   output logic                           o_req_ready
);

   import l2c_pkg::*;

   logic [PADDR_W-1:0]  w_addr;
   logic                w_is_bootrom;
   logic                w_is_serial;
   logic                w_is_kernel;
   logic                w_is_initrd;
   region_t             w_region;
   logic [NUM_TGT-1:0]  w_sel;

   assign w_addr = i_req_payload.addr;

   // ====================
   // Address decode
   // ====================
   assign w_is_bootrom = w_addr[PADDR_W-1:PAGE_LSB] == BOOTROM_BASE[PADDR_W-1:PAGE_LSB];
   assign w_is_serial  = w_addr[PADDR_W-1:PAGE_LSB] == SERIAL_BASE[PADDR_W-1:PAGE_LSB];
   assign w_is_kernel  = (w_addr >= KERNEL_LO) && (w_addr < KERNEL_HI);
   assign w_is_initrd  = (w_addr >= INITRD_LO) && (w_addr < INITRD_HI);

   // Ranges are disjoint so order only fixes the fallback
   always_comb begin
      if (w_is_bootrom) begin
         w_region = RGN_BOOTROM;
      end else if (w_is_serial) begin
         w_region = RGN_SERIAL;
      end else if (w_is_kernel) begin
         w_region = RGN_KERNEL;
      end else if (w_is_initrd) begin
         w_region = RGN_INITRD;
      end else begin
         w_region = RGN_L2;
      end
   end

   assign w_sel = NUM_TGT'(1) << w_region;

   // ====================
   // Steering
   // ====================
   assign o_tgt_req_valid = w_sel & {NUM_TGT{i_req_valid}};

   // Ready of the decoded target, independent of valid
   assign o_req_ready = |(w_sel & i_tgt_req_ready);

   // Decoded ranges must not overlap
   always_comb begin
      assert ($onehot0({w_is_initrd, w_is_kernel, w_is_serial, w_is_bootrom}))
         else $error("l2c_splitter: address %h matches more than one region", w_addr);
   end

endmodule

`default_nettype wire

/* verilog/l2c_pkg.sv */
`default_nettype none

package l2c_pkg;

   // ====================
   // Widths
   // ====================
   localparam int PADDR_W  = 32;
   localparam int DATA_W   = 32;
   localparam int STRB_W   = DATA_W / 8;
   localparam int NUM_TGT  = 5;
   localparam int PAGE_LSB = 12;

   typedef enum logic {
      CMD_RD = 1'b0,
      CMD_WR = 1'b1
   } mem_cmd_t;

   // Index into the target vector
   typedef enum logic [2:0] {
      RGN_BOOTROM = 3'd0,
      RGN_SERIAL  = 3'd1,
      RGN_KERNEL  = 3'd2,
      RGN_INITRD  = 3'd3,
      RGN_L2      = 3'd4
   } region_t;

   // ====================
   // Address map
   // ====================
   // Single 4 KiB pages
   localparam logic [PADDR_W-1:0] BOOTROM_BASE = 32'h0000_1000;
   localparam logic [PADDR_W-1:0] SERIAL_BASE  = 32'h5400_0000;
   // Half-open ranges
   localparam logic [PADDR_W-1:0] KERNEL_LO    = 32'h8020_0000;
   localparam logic [PADDR_W-1:0] KERNEL_HI    = 32'h8220_0000;
   localparam logic [PADDR_W-1:0] INITRD_LO    = 32'hffc8_4a00;
   localparam logic [PADDR_W-1:0] INITRD_HI    = 32'hffff_f000;

   typedef struct packed {
      mem_cmd_t            cmd;
      logic [PADDR_W-1:0]  addr;
      logic [DATA_W-1:0]   data;
      logic [STRB_W-1:0]   byte_en;
   } req_payload_t;

   typedef struct packed {
      logic [DATA_W-1:0]   data;
   } resp_payload_t;

endpackage

`default_nettype wire
